//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int DMEM_WORDS = 64; // data memory, in words

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL = 6'h00,
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_SLL = 3'd5
	} alu_op_e;

	// instruction word, two views of the same 32 bits
	typedef struct packed {
		opcode_e                opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		funct_e                funct;
	} instr_r_t;

	typedef struct packed {
		opcode_e                opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [15:0]           imm;
	} instr_i_t;

	//////////////////////////////////////////////////////////////////////
	// pipeline registers
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;  // immediate is operand b
		logic    zero_ext; // ori
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
	} ctrl_t;

	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		logic [DATA_W-1:0]     rs_val;
		logic [DATA_W-1:0]     rt_val;
		logic [DATA_W-1:0]     imm; // already extended
	} id_ex_t;

	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [REG_ADDR_W-1:0] rd; // final destination
		logic [DATA_W-1:0]     alu_result;
		logic [DATA_W-1:0]     store_data;
	} ex_mem_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     data;
	} wb_t;

endpackage

`default_nettype wire

//--- reg_file.sv
`default_nettype none
`timescale 1ns/1ns

module reg_file (
	input  wire                                clk,
	input  wire                                reset,
	input  wire  [cpu_pkg::REG_ADDR_W-1:0]     rs_addr,
	input  wire  [cpu_pkg::REG_ADDR_W-1:0]     rt_addr,
	input  wire  cpu_pkg::wb_t                 wr,
	output logic [cpu_pkg::DATA_W-1:0]         rs_val,
	output logic [cpu_pkg::DATA_W-1:0]         rt_val
);

	logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::NUM_REGS];
	logic                       wr_en;

	assign wr_en = wr.valid && (wr.rd != '0); // r0 is never written

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wr.rd] <= wr.data;
		end
	end

	// same-cycle write shows up on the read ports
	always_comb
	begin
		if (rs_addr == '0)
			rs_val = '0;
		else if (wr_en && wr.rd == rs_addr)
			rs_val = wr.data;
		else
			rs_val = regs[rs_addr];

		if (rt_addr == '0)
			rt_val = '0;
		else if (wr_en && wr.rd == rt_addr)
			rt_val = wr.data;
		else
			rt_val = regs[rt_addr];
	end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        instr_valid,
	input  wire  [31:0]                instr,
	input  wire  cpu_pkg::wb_t         wb,      // register write port
	output logic                       stall,
	output cpu_pkg::id_ex_t            id_ex
);

	cpu_pkg::instr_r_t            ir;
	cpu_pkg::instr_i_t            ii;
	cpu_pkg::ctrl_t               ctrl;
	cpu_pkg::id_ex_t              id_ex_next;
	logic [cpu_pkg::DATA_W-1:0]   rs_val;
	logic [cpu_pkg::DATA_W-1:0]   rt_val;

	assign ir = instr;
	assign ii = instr;

	//////////////////////////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////////////////////////

	function automatic cpu_pkg::ctrl_t decode_ctrl(input cpu_pkg::instr_r_t w);
		cpu_pkg::ctrl_t c;
		c = '0;
		c.alu_op = cpu_pkg::ALU_ADD;
		case (w.opcode)
			cpu_pkg::OP_RTYPE:
			begin
				c.reg_write = 1'b1;
				case (w.funct)
					cpu_pkg::F_ADD: c.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::F_SUB: c.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::F_AND: c.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::F_OR:  c.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::F_SLT: c.alu_op = cpu_pkg::ALU_SLT;
					cpu_pkg::F_SLL: c.alu_op = cpu_pkg::ALU_SLL;
					default:        c.reg_write = 1'b0; // unknown funct, nop
				endcase
			end
			cpu_pkg::OP_ADDI:
			begin
				c.use_imm   = 1'b1;
				c.reg_write = 1'b1;
			end
			cpu_pkg::OP_ORI:
			begin
				c.alu_op    = cpu_pkg::ALU_OR;
				c.use_imm   = 1'b1;
				c.zero_ext  = 1'b1;
				c.reg_write = 1'b1;
			end
			cpu_pkg::OP_LW:
			begin
				c.use_imm   = 1'b1; // base + offset
				c.mem_read  = 1'b1;
				c.reg_write = 1'b1;
			end
			cpu_pkg::OP_SW:
			begin
				c.use_imm   = 1'b1;
				c.mem_write = 1'b1;
			end
			default: c = c; // unknown opcode, nop
		endcase
		return c;
	endfunction

	assign ctrl = decode_ctrl(ir);

	reg_file u_reg_file (
		.clk     (clk),
		.reset   (reset),
		.rs_addr (ii.rs),
		.rt_addr (ii.rt),
		.wr      (wb),
		.rs_val  (rs_val),
		.rt_val  (rt_val)
	);

	// load-use hazard against the lw now in id_ex
	assign stall = instr_valid && id_ex.valid && id_ex.ctrl.mem_read &&
		(id_ex.rt == ii.rs || id_ex.rt == ii.rt);

	always_comb
	begin
		id_ex_next        = '0;
		id_ex_next.valid  = 1'b1;
		id_ex_next.ctrl   = ctrl;
		id_ex_next.rs     = ir.rs;
		id_ex_next.rt     = ir.rt;
		id_ex_next.rd     = ir.rd;
		id_ex_next.shamt  = ir.shamt;
		id_ex_next.rs_val = rs_val;
		id_ex_next.rt_val = rt_val;
		if (ctrl.zero_ext)
			id_ex_next.imm = {{(cpu_pkg::DATA_W-16){1'b0}}, ii.imm};
		else
			id_ex_next.imm = {{(cpu_pkg::DATA_W-16){ii.imm[15]}}, ii.imm};
	end

	//////////////////////////////////////////////////////////////////////
	// decode/execute register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			id_ex <= '0;
		else if (instr_valid && !stall)
			id_ex <= id_ex_next;
		else
			id_ex <= '0; // bubble
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none
`timescale 1ns/1ns

module execute_stage (
	input  wire                    clk,
	input  wire                    reset,
	input  wire  cpu_pkg::id_ex_t  id_ex,
	input  wire  cpu_pkg::wb_t     wb,
	output cpu_pkg::ex_mem_t       ex_mem
);

	logic [cpu_pkg::DATA_W-1:0]     op_a;
	logic [cpu_pkg::DATA_W-1:0]     rt_fwd;
	logic [cpu_pkg::DATA_W-1:0]     op_b;
	logic [cpu_pkg::DATA_W-1:0]     alu_y;
	logic [cpu_pkg::REG_ADDR_W-1:0] dest;

	// youngest producer wins, loads in ex_mem are not ready yet
	function automatic logic [cpu_pkg::DATA_W-1:0] fwd(
		input logic [cpu_pkg::REG_ADDR_W-1:0] idx,
		input logic [cpu_pkg::DATA_W-1:0]     dec_val,
		input cpu_pkg::ex_mem_t               em,
		input cpu_pkg::wb_t                   w
	);
		logic [cpu_pkg::DATA_W-1:0] v;
		v = dec_val;
		if (idx == '0)
			v = dec_val;
		else if (em.valid && em.ctrl.reg_write && !em.ctrl.mem_read && em.rd == idx)
			v = em.alu_result;
		else if (w.valid && w.rd == idx)
			v = w.data;
		return v;
	endfunction

	assign op_a   = fwd(id_ex.rs, id_ex.rs_val, ex_mem, wb);
	assign rt_fwd = fwd(id_ex.rt, id_ex.rt_val, ex_mem, wb);
	assign op_b   = id_ex.ctrl.use_imm ? id_ex.imm : rt_fwd;
	assign dest   = id_ex.ctrl.use_imm ? id_ex.rt : id_ex.rd; // i-type writes rt

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (id_ex.ctrl.alu_op)
			cpu_pkg::ALU_ADD: alu_y = op_a + op_b;
			cpu_pkg::ALU_SUB: alu_y = op_a - op_b;
			cpu_pkg::ALU_AND: alu_y = op_a & op_b;
			cpu_pkg::ALU_OR:  alu_y = op_a | op_b;
			cpu_pkg::ALU_SLT: alu_y = {{(cpu_pkg::DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			cpu_pkg::ALU_SLL: alu_y = rt_fwd << id_ex.shamt;
			default:          alu_y = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex_mem <= '0;
		else
		begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.rd         <= dest;
			ex_mem.alu_result <= alu_y;
			ex_mem.store_data <= rt_fwd; // forwarded for sw
		end
	end

endmodule

`default_nettype wire

//--- memory_stage.sv
`default_nettype none
`timescale 1ns/1ns

module memory_stage (
	input  wire                     clk,
	input  wire                     reset,
	input  wire  cpu_pkg::ex_mem_t  ex_mem,
	output cpu_pkg::wb_t            wb
);

	logic [cpu_pkg::DATA_W-1:0]             dmem [cpu_pkg::DMEM_WORDS];
	logic [$clog2(cpu_pkg::DMEM_WORDS)-1:0] word_addr;
	logic [cpu_pkg::DATA_W-1:0]             rd_data;

	// byte address, word aligned
	assign word_addr = ex_mem.alu_result[$clog2(cpu_pkg::DMEM_WORDS)+1:2];
	assign rd_data   = dmem[word_addr];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (ex_mem.valid && ex_mem.ctrl.mem_write)
		begin
			dmem[word_addr] <= ex_mem.store_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory/writeback register, also the result port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			wb <= '0;
		else
		begin
			wb.valid <= ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.rd != '0);
			wb.rd    <= ex_mem.rd;
			wb.data  <= ex_mem.ctrl.mem_read ? rd_data : ex_mem.alu_result;
		end
	end

endmodule

`default_nettype wire

//--- core_top.sv
`default_nettype none
`timescale 1ns/1ns

module core_top (
	input  wire                clk,
	input  wire                reset,
	input  wire                instr_valid,
	input  wire  [31:0]        instr,
	output wire                stall,
	output wire  cpu_pkg::wb_t result
);

	wire cpu_pkg::id_ex_t  id_ex;
	wire cpu_pkg::ex_mem_t ex_mem;
	wire cpu_pkg::wb_t     wb; // writeback loop, also leaves as result

	decode_stage u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.stall       (stall),
		.id_ex       (id_ex)
	);

	execute_stage u_execute (
		.clk    (clk),
		.reset  (reset),
		.id_ex  (id_ex),
		.wb     (wb),
		.ex_mem (ex_mem)
	);

	memory_stage u_memory (
		.clk    (clk),
		.reset  (reset),
		.ex_mem (ex_mem),
		.wb     (wb)
	);

	assign result = wb;

endmodule

`default_nettype wire

//--- core_assert.sv
`default_nettype none
`timescale 1ns/1ns

module core_assert (
	input wire               clk,
	input wire               reset,
	input wire               stall,
	input wire cpu_pkg::wb_t result
);

	// r0 writes are dropped in the memory stage
	a_result_rd_nonzero: assert property (
		@(posedge clk) disable iff (reset)
		result.valid |-> (result.rd != '0)
	) else $error("result valid with destination r0");

	// the bubble clears the hazard on the next edge
	a_stall_one_cycle: assert property (
		@(posedge clk) disable iff (reset)
		stall |=> !stall
	) else $error("stall held for two consecutive cycles");

	a_quiet_in_reset: assert property (
		@(posedge clk)
		reset |-> (!result.valid && !stall)
	) else $error("result valid or stall high during reset");

endmodule

bind core_top core_assert u_core_assert (
	.clk    (clk),
	.reset  (reset),
	.stall  (stall),
	.result (result)
);

`default_nettype wire

//--- core_tb.sv
`default_nettype none
`timescale 1ns/1ns

module core_tb;

	localparam int IDLE_CYCLES  = 5;
	localparam int DRAIN_CYCLES = 4; // pipeline depth plus one

	typedef struct packed {
		logic [31:0] word;
		logic        has_result;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        load_use; // the entry right after an lw that it reads
	} entry_t;

	logic              clk;
	logic              reset;
	logic              instr_valid;
	logic [31:0]       instr;
	wire               stall;
	wire cpu_pkg::wb_t result;

	entry_t            prog [$];
	cpu_pkg::wb_t      exp_q [$];
	logic              took;
	int                stall_cycles;
	int                expected_stalls;
	int                n_mismatch;
	int                n_unexpected;
	int                cycles;
	int                timeout_limit;

	core_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.stall       (stall),
		.result      (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// encoders and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] encode_r(input cpu_pkg::funct_e f, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		cpu_pkg::instr_r_t w;
		w.opcode = cpu_pkg::OP_RTYPE;
		w.rs     = rs;
		w.rt     = rt;
		w.rd     = rd;
		w.shamt  = shamt;
		w.funct  = f;
		return w;
	endfunction

	function automatic logic [31:0] encode_i(input cpu_pkg::opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		cpu_pkg::instr_i_t w;
		w.opcode = op;
		w.rs     = rs;
		w.rt     = rt;
		w.imm    = imm;
		return w;
	endfunction

	task automatic add_entry(input logic [31:0] word, input logic has_result,
		input logic [4:0] rd, input logic [31:0] data, input logic load_use);
		entry_t e;
		e.word       = word;
		e.has_result = has_result;
		e.rd         = rd;
		e.data       = data;
		e.load_use   = load_use;
		prog.push_back(e);
	endtask

	task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t exp);
		if (got !== exp)
		begin
			n_mismatch++;
			$display("mismatch at time %0t: result v=%b r%0d=%h, expected v=%b r%0d=%h",
				$time, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
		end
	endtask

	task automatic check_stall(input int got, input int exp);
		if (got != exp)
		begin
			n_mismatch++;
			$display("mismatch at time %0t: %0d stall cycles, expected %0d",
				$time, got, exp);
		end
	endtask

	// hand-worked program, registers all start at zero
	task automatic build_program;
		add_entry(encode_i(cpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'd5, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_ADDI, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2, 32'hfffffffd, 1'b0);
		add_entry(encode_r(cpu_pkg::F_ADD, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd3, 32'd2, 1'b0);
		add_entry(encode_r(cpu_pkg::F_SUB, 5'd3, 5'd1, 5'd4, 5'd0), 1'b1, 5'd4, 32'hfffffffd, 1'b0);
		add_entry(encode_r(cpu_pkg::F_AND, 5'd4, 5'd1, 5'd5, 5'd0), 1'b1, 5'd5, 32'd5, 1'b0);
		add_entry(encode_r(cpu_pkg::F_OR, 5'd2, 5'd1, 5'd6, 5'd0), 1'b1, 5'd6, 32'hfffffffd, 1'b0);
		add_entry(encode_r(cpu_pkg::F_SLT, 5'd2, 5'd1, 5'd7, 5'd0), 1'b1, 5'd7, 32'd1, 1'b0);
		add_entry(encode_r(cpu_pkg::F_SLT, 5'd1, 5'd4, 5'd8, 5'd0), 1'b1, 5'd8, 32'd0, 1'b0);
		add_entry(encode_r(cpu_pkg::F_SLL, 5'd0, 5'd1, 5'd9, 5'd4), 1'b1, 5'd9, 32'h50, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_ORI, 5'd0, 5'd10, 16'h8001), 1'b1, 5'd10, 32'h8001, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_ADDI, 5'd0, 5'd11, 16'h8001), 1'b1, 5'd11, 32'hffff8001, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_SW, 5'd0, 5'd10, 16'd8), 1'b0, 5'd0, 32'd0, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_SW, 5'd0, 5'd9, 16'd12), 1'b0, 5'd0, 32'd0, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_LW, 5'd0, 5'd12, 16'd8), 1'b1, 5'd12, 32'h8001, 1'b0);
		add_entry(encode_r(cpu_pkg::F_ADD, 5'd12, 5'd1, 5'd13, 5'd0), 1'b1, 5'd13, 32'h8006, 1'b1);
		add_entry(encode_i(cpu_pkg::OP_LW, 5'd0, 5'd14, 16'd12), 1'b1, 5'd14, 32'h50, 1'b0);
		add_entry(32'h0, 1'b0, 5'd0, 32'd0, 1'b0); // nop, one gap after the lw
		add_entry(encode_r(cpu_pkg::F_ADD, 5'd14, 5'd0, 5'd15, 5'd0), 1'b1, 5'd15, 32'h50, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 16'd7), 1'b0, 5'd0, 32'd0, 1'b0);
		add_entry(encode_r(cpu_pkg::F_ADD, 5'd0, 5'd1, 5'd16, 5'd0), 1'b1, 5'd16, 32'd5, 1'b0);
		add_entry(encode_r(cpu_pkg::F_OR, 5'd0, 5'd0, 5'd17, 5'd0), 1'b1, 5'd17, 32'd0, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_SW, 5'd0, 5'd7, 16'd16), 1'b0, 5'd0, 32'd0, 1'b0);
		add_entry(encode_i(cpu_pkg::OP_LW, 5'd0, 5'd18, 16'd16), 1'b1, 5'd18, 32'd1, 1'b0);
		add_entry(encode_r(cpu_pkg::F_SUB, 5'd1, 5'd18, 5'd19, 5'd0), 1'b1, 5'd19, 32'd4, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitors
	//////////////////////////////////////////////////////////////////////

	// acceptance seen like a flop would see it
	always @(posedge clk or posedge reset)
	begin
		if (reset)
			took <= 1'b0;
		else
		begin
			took <= instr_valid && !stall;
			if (stall)
				stall_cycles <= stall_cycles + 1;
		end
	end

	always @(negedge clk)
	begin
		if (!reset && result.valid)
		begin
			if (exp_q.size() == 0)
			begin
				n_unexpected++;
				$display("unexpected result at time %0t: r%0d = %h appeared with none expected",
					$time, result.rd, result.data);
			end
			else
				check_wb(result, exp_q.pop_front());
		end
	end

	always @(negedge clk)
	begin
		if (!reset)
		begin
			cycles++;
			if (cycles > timeout_limit)
			begin
				$display("timeout: %0d results still missing after %0d cycles",
					exp_q.size(), cycles);
				$display("RESULT: FAIL");
				$finish;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		build_program();
		foreach (prog[i])
		begin
			if (prog[i].has_result)
				exp_q.push_back({1'b1, prog[i].rd, prog[i].data});
			if (prog[i].load_use)
				expected_stalls++;
		end
		timeout_limit = prog.size() * 4 + 40;

		repeat (10) @(negedge clk);
		reset = 1'b0;

		repeat (IDLE_CYCLES)
		begin
			@(negedge clk);
			check_wb(result, '0); // quiet pipeline
		end
		check_stall(stall_cycles, 0);

		foreach (prog[i])
		begin
			instr_valid = 1'b1;
			instr       = prog[i].word;
			do
				@(negedge clk);
			while (!took); // held through a stall
		end
		instr_valid = 1'b0;
		instr       = '0;

		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (DRAIN_CYCLES) @(negedge clk); // catch stray results
		check_stall(stall_cycles, expected_stalls);

		$display("errors: %0d mismatches, %0d unexpected results", n_mismatch, n_unexpected);
		if (n_mismatch == 0 && n_unexpected == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
cpu_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core_top.sv
core_assert.sv
core_tb.sv
